//--- design/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Datapath word width
`define CORE_WORD_W 32

// Instruction memory address width, 256 instructions
`define CORE_IMEM_AW 8

// Register address width, 32 registers
`define CORE_RF_AW 5

// Instruction width
// opcode, rd and rs_imm fields
`define CORE_OPCODE_W 6
`define CORE_INSTR_W 16

// Network packet fields
// ID selects the core, address is wider than any core address
`define CORE_NET_ID_W 10
`define CORE_NET_ADDR_W 10

// Network command width
`define CORE_NET_OP_W 2

// Core state width
`define CORE_STATE_W 2

`endif

//--- design/core_pkg.sv
`include "core_defines.svh"

package core_pkg;

    // Data word and addresses
    typedef logic [`CORE_WORD_W-1:0] word_t;
    typedef logic [`CORE_IMEM_AW-1:0] pc_t;
    typedef logic [`CORE_RF_AW-1:0] rf_addr_t;

    // Opcodes
    // Unused codes decode as NOP
    typedef enum logic [`CORE_OPCODE_W-1:0] {
        OP_NOP  = 6'h00,
        OP_ADD  = 6'h01,
        OP_SUB  = 6'h02,
        OP_AND  = 6'h03,
        OP_OR   = 6'h04,
        OP_ADDI = 6'h05,
        OP_MOV  = 6'h06,
        OP_BNEZ = 6'h07,
        OP_WAIT = 6'h08
    } opcode_e;

    // Instruction format
    // rs_imm is a source register, or a signed immediate for ADDI and BNEZ
    typedef struct packed {
        opcode_e                opcode;
        rf_addr_t               rd;
        logic [`CORE_RF_AW-1:0] rs_imm;
    } instr_t;

    localparam instr_t INSTR_NOP = '{opcode: OP_NOP, rd: '0, rs_imm: '0};

    // Network commands
    typedef enum logic [`CORE_NET_OP_W-1:0] {
        NET_NONE  = 2'd0,
        NET_INSTR = 2'd1,
        NET_REG   = 2'd2,
        NET_PC    = 2'd3
    } net_op_e;

    // Core states
    typedef enum logic [`CORE_STATE_W-1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        ERR  = 2'd2
    } core_state_e;

endpackage

//--- design/fetch_stage.sv
`include "core_defines.svh"

module fetch_stage
    import core_pkg::*;
(
    input  logic   clk,
    input  logic   n_reset,
    input  logic   stall_i,
    input  logic   pc_load_i,
    input  pc_t    pc_load_value_i,
    input  logic   imem_we_i,
    input  pc_t    imem_waddr_i,
    input  instr_t imem_wdata_i,
    input  logic   branch_taken_i,
    input  pc_t    branch_target_i,
    input  logic   wait_seen_i,
    output instr_t instr_o,
    output pc_t    pc_o
);

    localparam int IMEM_DEPTH = 2 ** `CORE_IMEM_AW;

    instr_t imem [IMEM_DEPTH];
    instr_t imem_rdata;
    instr_t instr_r;
    pc_t    pc_r;
    pc_t    pc_next;
    pc_t    pc_d_r;

    // Next PC
    // Network load beats stall, stall beats branch
    // A WAIT in flight freezes the PC
    always_comb
    begin
        if (pc_load_i)
            pc_next = pc_load_value_i;
        else if (stall_i)
            pc_next = pc_r;
        else if (branch_taken_i)
            pc_next = branch_target_i;
        else if (wait_seen_i)
            pc_next = pc_r;
        else
            pc_next = pc_r + pc_t'(1);
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
            pc_r <= '0;
        else
            pc_r <= pc_next;
    end

    // Instruction memory, read with the next PC
    // Read data arrives together with the PC register
    // A network write takes the port, read data holds the last fetch
    always_ff @(posedge clk)
    begin
        if (imem_we_i)
            imem[imem_waddr_i] <= imem_wdata_i;
        else
            imem_rdata <= imem[pc_next];
    end

    // Fetch/decode register
    // Squashed to NOP on a taken branch or while a WAIT is in flight
    always_ff @(posedge clk)
    begin
        if (!n_reset)
            instr_r <= INSTR_NOP;
        else if (!stall_i)
        begin
            if (branch_taken_i || wait_seen_i)
                instr_r <= INSTR_NOP;
            else
                instr_r <= imem_rdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_i)
            pc_d_r <= pc_r;
    end

    assign instr_o = instr_r;
    assign pc_o    = pc_d_r;

    // Controller never issues a PC load and an instruction write together
    a_no_load_and_write: assert property (
        @(posedge clk) disable iff (!n_reset)
        !(pc_load_i && imem_we_i)
    );

endmodule

//--- design/reg_file.sv
`include "core_defines.svh"

module reg_file
    import core_pkg::*;
(
    input  logic     clk,
    input  rf_addr_t rs_addr_i,
    input  rf_addr_t rd_addr_i,
    input  logic     we_i,
    input  rf_addr_t waddr_i,
    input  word_t    wdata_i,
    output word_t    rs_val_o,
    output word_t    rd_val_o
);

    localparam int NUM_REGS = 2 ** `CORE_RF_AW;

    word_t regs [NUM_REGS];

    // Single write port
    // Writes to register 0 are dropped
    always_ff @(posedge clk)
    begin
        if (we_i && (waddr_i != '0))
            regs[waddr_i] <= wdata_i;
    end

    // Combinational reads
    // Register 0 always reads zero
    always_comb
    begin
        if (rs_addr_i == '0)
            rs_val_o = '0;
        else
            rs_val_o = regs[rs_addr_i];
    end

    always_comb
    begin
        if (rd_addr_i == '0)
            rd_val_o = '0;
        else
            rd_val_o = regs[rd_addr_i];
    end

    // Network and writeback sources both deliver known data
    a_wdata_known: assert property (
        @(posedge clk)
        we_i |-> !$isunknown(wdata_i)
    );

endmodule

//--- design/exec_stage.sv
module exec_stage
    import core_pkg::*;
(
    input  logic     clk,
    input  logic     n_reset,
    input  logic     stall_i,
    input  instr_t   instr_i,
    input  pc_t      pc_i,
    input  word_t    rs_val_i,
    input  word_t    rd_val_i,
    output rf_addr_t rs_addr_o,
    output rf_addr_t rd_addr_o,
    output logic     branch_taken_o,
    output pc_t      branch_target_o,
    output logic     wait_seen_o,
    output logic     wait_retired_o,
    output logic     wb_we_o,
    output rf_addr_t wb_addr_o,
    output word_t    wb_data_o
);

    instr_t   ex_instr_r;
    logic     ex_writes_r;
    pc_t      ex_pc_r;
    word_t    ex_rs_val_r;
    word_t    ex_rd_val_r;
    logic     dec_writes;
    word_t    dec_rs_val;
    word_t    dec_rd_val;
    word_t    imm_ext;
    word_t    alu_result;
    logic     wb_valid_r;
    rf_addr_t wb_addr_r;
    word_t    wb_data_r;

    // Operand bypass
    // Execute result first, then the writeback register
    function automatic word_t forward(rf_addr_t addr, word_t rf_val);
        word_t val;
        val = rf_val;
        if (addr != '0)
        begin
            if (ex_writes_r && (ex_instr_r.rd == addr))
                val = alu_result;
            else if (wb_valid_r && (wb_addr_r == addr))
                val = wb_data_r;
        end
        return val;
    endfunction

    assign rs_addr_o = instr_i.rs_imm;
    assign rd_addr_o = instr_i.rd;

    // Decode, only ALU ops with a nonzero rd write back
    always_comb
    begin
        case (instr_i.opcode)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI, OP_MOV:
                dec_writes = (instr_i.rd != '0);
            default:
                dec_writes = 1'b0;
        endcase
        dec_rs_val = forward(instr_i.rs_imm, rs_val_i);
        dec_rd_val = forward(instr_i.rd, rd_val_i);
    end

    // Decode/execute register, squashed by a taken branch
    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            ex_instr_r  <= INSTR_NOP;
            ex_writes_r <= 1'b0;
        end
        else if (!stall_i)
        begin
            ex_instr_r  <= branch_taken_o ? INSTR_NOP : instr_i;
            ex_writes_r <= !branch_taken_o && dec_writes;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall_i)
        begin
            ex_pc_r     <= pc_i;
            ex_rs_val_r <= dec_rs_val;
            ex_rd_val_r <= dec_rd_val;
        end
    end

    // ALU, rd is always the left operand
    assign imm_ext = word_t'(signed'(ex_instr_r.rs_imm));

    always_comb
    begin
        case (ex_instr_r.opcode)
            OP_ADD:  alu_result = ex_rd_val_r + ex_rs_val_r;
            OP_SUB:  alu_result = ex_rd_val_r - ex_rs_val_r;
            OP_AND:  alu_result = ex_rd_val_r & ex_rs_val_r;
            OP_OR:   alu_result = ex_rd_val_r | ex_rs_val_r;
            OP_ADDI: alu_result = ex_rd_val_r + imm_ext;
            OP_MOV:  alu_result = ex_rs_val_r;
            default: alu_result = '0;
        endcase
    end

    // BNEZ offset is relative to the branch itself
    assign branch_taken_o  = (ex_instr_r.opcode == OP_BNEZ) && (ex_rd_val_r != '0);
    assign branch_target_o = ex_pc_r + pc_t'(signed'(ex_instr_r.rs_imm));

    assign wait_seen_o    = (instr_i.opcode == OP_WAIT) || (ex_instr_r.opcode == OP_WAIT);
    assign wait_retired_o = (ex_instr_r.opcode == OP_WAIT) && !stall_i;

    // Writeback register
    always_ff @(posedge clk)
    begin
        if (!n_reset)
            wb_valid_r <= 1'b0;
        else if (!stall_i)
            wb_valid_r <= ex_writes_r;
    end

    always_ff @(posedge clk)
    begin
        if (!stall_i)
        begin
            wb_addr_r <= ex_instr_r.rd;
            wb_data_r <= alu_result;
        end
    end

    assign wb_we_o   = wb_valid_r;
    assign wb_addr_o = wb_addr_r;
    assign wb_data_o = wb_data_r;

    a_no_wb_r0: assert property (
        @(posedge clk) disable iff (!n_reset)
        wb_we_o |-> (wb_addr_o != '0)
    );

endmodule

//--- design/core_ctrl.sv
`include "core_defines.svh"

module core_ctrl
    import core_pkg::*;
#(
    parameter logic [`CORE_NET_ID_W-1:0] CORE_ID = `CORE_NET_ID_W'(1)
)
(
    input  logic                          clk,
    input  logic                          n_reset,
    input  logic [`CORE_NET_ID_W-1:0]     net_id_i,
    input  net_op_e                       net_op_i,
    input  logic [`CORE_NET_ADDR_W-1:0]   net_addr_i,
    input  logic                          wb_we_i,
    input  logic                          wait_retired_i,
    output logic                          imem_we_o,
    output logic                          rf_net_we_o,
    output logic                          pc_load_o,
    output logic                          stall_o,
    output core_state_e                   state_o,
    output logic                          exception_o
);

    logic        id_match;
    logic        pc_cmd;
    core_state_e state_r;
    core_state_e state_n;
    logic        exception_r;

    // Packet decode
    // Address bits above the target range must be zero
    assign id_match = (net_id_i == CORE_ID);
    assign pc_cmd   = id_match && (net_op_i == NET_PC);

    assign imem_we_o = id_match && (net_op_i == NET_INSTR)
                       && (net_addr_i[`CORE_NET_ADDR_W-1:`CORE_IMEM_AW] == '0);
    assign rf_net_we_o = id_match && (net_op_i == NET_REG)
                         && (net_addr_i[`CORE_NET_ADDR_W-1:`CORE_RF_AW] == '0);

    // PC load only starts an idle core
    assign pc_load_o = pc_cmd && (state_r == IDLE);

    // Stall when not running, when imem port is taken by the network,
    // or when the network and a pending writeback want the RF port
    assign stall_o = (state_r != RUN) || imem_we_o || (rf_net_we_o && wb_we_i);

    // Core FSM
    always_comb
    begin
        state_n = state_r;
        case (state_r)
            IDLE:
                if (pc_cmd)
                    state_n = RUN;
            RUN:
                if (wait_retired_i)
                    state_n = IDLE;
            default:
                state_n = ERR;
        endcase
        // PC write to a busy core is fatal
        if (pc_cmd && (state_r != IDLE))
            state_n = ERR;
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            state_r     <= IDLE;
            exception_r <= 1'b0;
        end
        else
        begin
            state_r <= state_n;
            if (state_n == ERR)
                exception_r <= 1'b1;
        end
    end

    assign state_o     = state_r;
    assign exception_o = exception_r;

    a_err_sticky: assert property (
        @(posedge clk) disable iff (!n_reset)
        (state_r == ERR) |=> (state_r == ERR) && exception_o
    );

endmodule

//--- design/core_top.sv
`include "core_defines.svh"

module core_top
    import core_pkg::*;
#(
    parameter logic [`CORE_NET_ID_W-1:0] CORE_ID = `CORE_NET_ID_W'(1)
)
(
    input  logic                        clk,
    input  logic                        n_reset,
    input  logic [`CORE_NET_ID_W-1:0]   net_id_i,
    input  net_op_e                     net_op_i,
    input  logic [`CORE_NET_ADDR_W-1:0] net_addr_i,
    input  word_t                       net_data_i,
    output core_state_e                 state_o,
    output logic                        exception_o,
    output logic                        retire_valid_o,
    output rf_addr_t                    retire_addr_o,
    output word_t                       retire_data_o
);

    logic     imem_we;
    logic     rf_net_we;
    logic     pc_load;
    logic     stall;
    logic     wb_we;
    rf_addr_t wb_addr;
    word_t    wb_data;
    logic     wait_retired;
    logic     branch_taken;
    pc_t      branch_target;
    logic     wait_seen;
    instr_t   dec_instr;
    pc_t      dec_pc;
    rf_addr_t rs_addr;
    rf_addr_t rd_addr;
    word_t    rs_val;
    word_t    rd_val;
    logic     pipe_we;
    logic     rf_we;
    rf_addr_t rf_waddr;
    word_t    rf_wdata;

    core_ctrl #(
        .CORE_ID(CORE_ID)
    ) u_ctrl (
        .clk(clk), .n_reset(n_reset),
        .net_id_i(net_id_i), .net_op_i(net_op_i), .net_addr_i(net_addr_i),
        .wb_we_i(wb_we), .wait_retired_i(wait_retired),
        .imem_we_o(imem_we), .rf_net_we_o(rf_net_we), .pc_load_o(pc_load),
        .stall_o(stall), .state_o(state_o), .exception_o(exception_o)
    );

    fetch_stage u_fetch (
        .clk(clk), .n_reset(n_reset), .stall_i(stall),
        .pc_load_i(pc_load), .pc_load_value_i(net_addr_i[`CORE_IMEM_AW-1:0]),
        .imem_we_i(imem_we), .imem_waddr_i(net_addr_i[`CORE_IMEM_AW-1:0]),
        .imem_wdata_i(instr_t'(net_data_i[`CORE_INSTR_W-1:0])),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .wait_seen_i(wait_seen), .instr_o(dec_instr), .pc_o(dec_pc)
    );

    // Network owns the write port, a held writeback retires when stall drops
    assign pipe_we  = wb_we && !stall;
    assign rf_we    = rf_net_we || pipe_we;
    assign rf_waddr = rf_net_we ? net_addr_i[`CORE_RF_AW-1:0] : wb_addr;
    assign rf_wdata = rf_net_we ? net_data_i : wb_data;

    reg_file u_rf (
        .clk(clk), .rs_addr_i(rs_addr), .rd_addr_i(rd_addr),
        .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
        .rs_val_o(rs_val), .rd_val_o(rd_val)
    );

    exec_stage u_exec (
        .clk(clk), .n_reset(n_reset), .stall_i(stall),
        .instr_i(dec_instr), .pc_i(dec_pc), .rs_val_i(rs_val), .rd_val_i(rd_val),
        .rs_addr_o(rs_addr), .rd_addr_o(rd_addr),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .wait_seen_o(wait_seen), .wait_retired_o(wait_retired),
        .wb_we_o(wb_we), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
    );

    // Retire trace mirrors pipeline writes
    assign retire_valid_o = rf_we && !rf_net_we;
    assign retire_addr_o  = rf_waddr;
    assign retire_data_o  = rf_wdata;

endmodule

//--- tests/core_tb.sv
`include "core_defines.svh"

module core_tb
    import core_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef logic [`CORE_NET_ID_W-1:0] net_id_t;
    typedef logic [`CORE_NET_ADDR_W-1:0] net_addr_t;

    localparam net_id_t OWN_ID     = net_id_t'(1);
    localparam net_id_t FOREIGN_ID = net_id_t'(2);

    logic        clk;
    logic        n_reset;
    net_id_t     net_id_i;
    net_op_e     net_op_i;
    net_addr_t   net_addr_i;
    word_t       net_data_i;
    core_state_e state_o;
    logic        exception_o;
    logic        retire_valid_o;
    rf_addr_t    retire_addr_o;
    word_t       retire_data_o;

    // Reference model and expected retire queue
    word_t       model_regs [32];
    instr_t      model_imem [256];
    rf_addr_t    exp_addr [$];
    word_t       exp_data [$];
    pc_t         load_pc;
    logic [31:0] rng_state = 32'h1012;
    word_t       net_val;
    string       test_name;
    int          errors;
    int          test_start_errors;
    int          tests_run;
    int          tests_failed;
    int          modeled_steps;
    int          cycle_count;

    core_top UUT (
        .clk(clk), .n_reset(n_reset),
        .net_id_i(net_id_i), .net_op_i(net_op_i), .net_addr_i(net_addr_i),
        .net_data_i(net_data_i), .state_o(state_o), .exception_o(exception_o),
        .retire_valid_o(retire_valid_o), .retire_addr_o(retire_addr_o),
        .retire_data_o(retire_data_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 32-bit xorshift
    function automatic word_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic word_t sign_extend(logic [4:0] v);
        return {{(`CORE_WORD_W-5){v[4]}}, v};
    endfunction

    function automatic word_t read_model_reg(rf_addr_t a);
        return (a == '0) ? '0 : model_regs[a];
    endfunction

    function automatic instr_t encode(opcode_e op, int rd, int rs_imm);
        instr_t ins;
        ins.opcode = op;
        ins.rd     = rf_addr_t'(rd);
        ins.rs_imm = rf_addr_t'(rs_imm);
        return ins;
    endfunction

    // One packet per cycle, entered 1 ns after a rising edge
    task automatic send_packet(net_id_t id, net_op_e op, net_addr_t addr, word_t data);
        net_id_i   = id;
        net_op_i   = op;
        net_addr_i = addr;
        net_data_i = data;
        @(posedge clk);
        #1;
        net_id_i = '0;
        net_op_i = NET_NONE;
    endtask

    // Append one instruction to the program in both DUT and model
    task automatic emit(opcode_e op, int rd, int rs_imm);
        instr_t ins;
        ins = encode(op, rd, rs_imm);
        model_imem[load_pc] = ins;
        send_packet(OWN_ID, NET_INSTR, net_addr_t'(load_pc),
                    {{(`CORE_WORD_W-`CORE_INSTR_W){1'b0}}, ins});
        load_pc = load_pc + pc_t'(1);
    endtask

    task automatic load_registers();
        word_t v;
        for (int r = 1; r < 32; r++)
        begin
            v = next_random();
            model_regs[rf_addr_t'(r)] = v;
            send_packet(OWN_ID, NET_REG, net_addr_t'(r), v);
        end
    endtask

    // In-order execution from start to WAIT
    // Every register write lands in the expected queue
    task automatic run_model(pc_t start);
        pc_t    pc;
        instr_t ins;
        word_t  a;
        word_t  b;
        word_t  res;
        logic   writes;
        logic   done;
        int     steps;
        pc    = start;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 1000)
        begin
            ins    = model_imem[pc];
            a      = read_model_reg(ins.rd);
            b      = read_model_reg(ins.rs_imm);
            res    = '0;
            writes = 1'b1;
            steps++;
            case (ins.opcode)
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_ADDI: res = a + sign_extend(ins.rs_imm);
                OP_MOV:  res = b;
                default: writes = 1'b0;
            endcase
            // r0 never takes a write
            if (writes && ins.rd != '0)
            begin
                model_regs[ins.rd] = res;
                exp_addr.push_back(ins.rd);
                exp_data.push_back(res);
            end
            done = (ins.opcode == OP_WAIT);
            if (ins.opcode == OP_BNEZ && a != '0)
                pc = pc + pc_t'(sign_extend(ins.rs_imm));
            else
                pc = pc + pc_t'(1);
        end
        modeled_steps += steps;
    endtask

    task automatic begin_test(string name, pc_t base);
        test_name         = name;
        test_start_errors = errors;
        load_pc           = base;
    endtask

    task automatic start_core(pc_t start);
        send_packet(OWN_ID, NET_PC, net_addr_t'(start), '0);
        @(negedge clk);
        a_started: assert (state_o == RUN)
        else
        begin
            $display("%s: core did not enter RUN after the PC write", test_name);
            errors++;
        end
    endtask

    // End of program is the state leaving RUN
    task automatic wait_idle();
        while (state_o == RUN)
            @(negedge clk);
        a_back_idle: assert (state_o == IDLE)
        else
        begin
            $display("[FAIL] %s end state expected %0d actual %0d", test_name, IDLE, state_o);
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic wait_first_retire();
        while (!retire_valid_o)
            @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic finish_test();
        a_all_retired: assert (exp_addr.size() == 0)
        else
        begin
            $display("%s: %0d expected writes never retired", test_name, exp_addr.size());
            errors++;
        end
        tests_run++;
        if (errors != test_start_errors)
            tests_failed++;
        $display("Test %-14s %s", test_name, (errors == test_start_errors) ? "passed" : "had errors");
    endtask

    // Retire trace against the head of the model queue, mid-cycle
    always @(negedge clk)
    begin
        if (n_reset && retire_valid_o)
        begin
            a_retire_expected: assert (exp_addr.size() != 0)
            else
            begin
                $display("%s: retire to r%0d when none was expected", test_name, retire_addr_o);
                errors++;
            end
            if (exp_addr.size() != 0)
            begin
                a_retire_addr: assert (retire_addr_o == exp_addr[0])
                else
                begin
                    $display("[FAIL] %s retire address expected %0d actual %0d",
                             test_name, exp_addr[0], retire_addr_o);
                    errors++;
                end
                a_retire_data: assert (retire_data_o == exp_data[0])
                else
                begin
                    $display("[FAIL] %s retire data to r%0d expected %h actual %h",
                             test_name, exp_addr[0], exp_data[0], retire_data_o);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    a_retire_in_run: assert property (
        @(posedge clk) disable iff (!n_reset)
        retire_valid_o |-> (state_o == RUN)
    )
    else
    begin
        $display("%s: retire event outside the RUN state", test_name);
        errors++;
    end

    // ERR and the exception flag hold until reset
    a_err_sticky: assert property (
        @(posedge clk) disable iff (!n_reset)
        exception_o |=> exception_o && (state_o == ERR)
    )
    else
    begin
        $display("%s: exception or ERR state cleared without reset", test_name);
        errors++;
    end

    // Run limit grows with every modeled instruction
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count > 200 + 4 * modeled_steps)
        begin
            $display("Timeout after %0d cycles in test %s", cycle_count, test_name);
            $display("Something failed");
            $finish;
        end
    end

    initial
    begin
        n_reset    = 1'b0;
        net_id_i   = '0;
        net_op_i   = NET_NONE;
        net_addr_i = '0;
        net_data_i = '0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        modeled_steps = 0;
        cycle_count   = 0;
        for (int r = 0; r < 32; r++)
            model_regs[rf_addr_t'(r)] = '0;
        repeat (3) @(posedge clk);
        #1;
        n_reset = 1'b1;

        // Each ALU op once, independent operands
        begin_test("alu_ops", pc_t'(0));
        load_registers();
        emit(OP_ADD, 1, 2);
        emit(OP_SUB, 3, 4);
        emit(OP_AND, 5, 6);
        emit(OP_OR, 7, 8);
        emit(OP_ADDI, 9, -3);
        emit(OP_ADDI, 10, 7);
        emit(OP_MOV, 11, 12);
        emit(OP_ADD, 0, 13);
        emit(OP_NOP, 0, 0);
        emit(OP_WAIT, 0, 0);
        run_model(pc_t'(0));
        start_core(pc_t'(0));
        wait_idle();
        finish_test();

        // Dependencies at distance one and two on both operands
        begin_test("forwarding", pc_t'(16));
        emit(OP_ADD, 14, 15);
        emit(OP_SUB, 16, 14);
        emit(OP_OR, 17, 14);
        emit(OP_ADDI, 16, 9);
        emit(OP_AND, 16, 17);
        emit(OP_MOV, 18, 16);
        emit(OP_ADD, 18, 18);
        emit(OP_WAIT, 0, 0);
        run_model(pc_t'(16));
        start_core(pc_t'(16));
        wait_idle();
        finish_test();

        // Countdown of five, the ADDI after BNEZ is flushed while looping
        begin_test("branch_loop", pc_t'(32));
        emit(OP_MOV, 6, 0);
        emit(OP_ADDI, 6, 5);
        emit(OP_MOV, 7, 0);
        emit(OP_ADD, 7, 6);
        emit(OP_ADDI, 6, -1);
        emit(OP_BNEZ, 6, -2);
        emit(OP_ADDI, 8, 1);
        emit(OP_WAIT, 0, 0);
        // Packets for another core must change nothing
        send_packet(FOREIGN_ID, NET_REG, net_addr_t'(8), next_random());
        send_packet(FOREIGN_ID, NET_INSTR, net_addr_t'(36), '0);
        send_packet(FOREIGN_ID, NET_PC, net_addr_t'(0), '0);
        a_foreign_ignored: assert (state_o == IDLE)
        else
        begin
            $display("%s: foreign PC write started the core", test_name);
            errors++;
        end
        run_model(pc_t'(32));
        start_core(pc_t'(32));
        wait_idle();
        finish_test();

        // Nothing past WAIT may retire
        begin_test("wait_idle", pc_t'(48));
        emit(OP_ADDI, 19, 1);
        emit(OP_WAIT, 0, 0);
        emit(OP_ADDI, 19, 2);
        emit(OP_MOV, 21, 19);
        run_model(pc_t'(48));
        start_core(pc_t'(48));
        wait_idle();
        repeat (8) @(posedge clk);
        #1;
        a_stays_idle: assert (state_o == IDLE)
        else
        begin
            $display("%s: core left IDLE without a PC write", test_name);
            errors++;
        end
        finish_test();

        // Network write to r20 while writebacks are pending
        begin_test("net_reg_in_run", pc_t'(64));
        for (int i = 0; i < 7; i++)
        begin
            emit(OP_ADDI, 22 + i, i + 1);
        end
        emit(OP_MOV, 29, 20);
        emit(OP_ADD, 30, 20);
        emit(OP_ADDI, 20, 1);
        emit(OP_MOV, 31, 20);
        emit(OP_WAIT, 0, 0);
        net_val = next_random();
        model_regs[20] = net_val;
        run_model(pc_t'(64));
        start_core(pc_t'(64));
        wait_first_retire();
        send_packet(OWN_ID, NET_REG, net_addr_t'(20), net_val);
        wait_idle();
        finish_test();

        // Long loop, interrupted by a second PC write
        begin_test("pc_write_in_run", pc_t'(80));
        emit(OP_MOV, 21, 0);
        emit(OP_ADDI, 21, 15);
        emit(OP_ADDI, 21, 15);
        emit(OP_ADDI, 22, 1);
        emit(OP_ADDI, 21, -1);
        emit(OP_BNEZ, 21, -2);
        emit(OP_WAIT, 0, 0);
        run_model(pc_t'(80));
        start_core(pc_t'(80));
        wait_first_retire();
        repeat (3) @(posedge clk);
        #1;
        send_packet(OWN_ID, NET_PC, net_addr_t'(0), '0);
        a_err_entered: assert (state_o == ERR && exception_o)
        else
        begin
            $display("%s: PC write in RUN did not raise the exception", test_name);
            errors++;
        end
        // The rest of the loop never runs
        exp_addr.delete();
        exp_data.delete();
        send_packet(OWN_ID, NET_REG, net_addr_t'(1), next_random());
        send_packet(OWN_ID, NET_INSTR, net_addr_t'(0), '0);
        send_packet(OWN_ID, NET_PC, net_addr_t'(0), '0);
        repeat (4) @(posedge clk);
        #1;
        a_err_held: assert (state_o == ERR && exception_o)
        else
        begin
            $display("%s: ERR state lost after later packets", test_name);
            errors++;
        end
        n_reset = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        n_reset = 1'b1;
        a_reset_clears: assert (state_o == IDLE && !exception_o)
        else
        begin
            $display("%s: reset did not clear ERR and the exception", test_name);
            errors++;
        end
        finish_test();

        $display("Tests: %0d run, %0d with errors, %0d failed checks",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- tb.f
+incdir+design
design/core_pkg.sv
design/fetch_stage.sv
design/reg_file.sv
design/exec_stage.sv
design/core_ctrl.sv
design/core_top.sv
tests/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := core_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG  := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) design/core_defines.svh
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only if the testbench prints the pass line
sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
